// ==== filelist.f ====
+incdir+logic
logic/aesRoundPkg.sv
logic/subRoundIf.sv
logic/byteSubstitute.sv
logic/roundCombine.sv
logic/aesRoundWord.sv
verification/aesRoundWord_assert.sv
verification/aesRoundWordTb.sv

// ==== logic/aesRoundPkg.sv ====
package aesRoundPkg;

    // datapath geometry of one column slice
    localparam int byteBits  = 8;
    localparam int lanes     = 4;                  // bytes per state word
    localparam int wordBits  = byteBits * lanes;
    localparam int sboxDepth = 1 << byteBits;      // one entry per byte value
    localparam int opBits    = 2;

    typedef logic [byteBits-1:0] aesByte_t;
    typedef logic [wordBits-1:0] aesWord_t;

    // ascending packed range puts lane 0 in the top byte, as the caller expects
    typedef aesByte_t [0:lanes-1] laneBytes_t;

    // reduction term for xtime in GF(2^8), x^8 + x^4 + x^3 + x + 1
    localparam aesByte_t gfPoly = 8'h1B;

    // round opcode, one per transaction and shared by all four lanes
    typedef enum logic [opBits-1:0] {
        opInitial = 2'd0,    // plaintext xor key
        opMiddle  = 2'd1,    // subbytes, mixcolumns, addroundkey
        opFinal   = 2'd2     // subbytes, addroundkey
    } roundOp_t;

endpackage

// ==== logic/aesRoundWord.sv ====
`timescale 1ns/1ns

module aesRoundWord (
    input  logic                    CLK,
    input  logic                    rstN,

    // request side, one column of gathered state bytes per transfer
    input  logic                    inValid,
    output logic                    inReady,
    input  aesRoundPkg::laneBytes_t stateIn,   // already shifted by the caller
    input  aesRoundPkg::aesWord_t   keyIn,     // round key word
    input  aesRoundPkg::aesWord_t   plainIn,   // used by the initial round only
    input  aesRoundPkg::roundOp_t   opIn,

    // result side
    output logic                    outValid,
    input  logic                    outReady,
    output aesRoundPkg::aesWord_t   outWord
);

    // link between the lookup stage and the combine stage
    subRoundIf subLink ();

    byteSubstitute subStage (
        .CLK     (CLK),
        .rstN    (rstN),
        .inValid (inValid),
        .stateIn (stateIn),
        .keyIn   (keyIn),
        .plainIn (plainIn),
        .opIn    (opIn),
        .inReady (inReady),
        .subOut  (subLink.producer)
    );

    roundCombine combineStage (
        .CLK      (CLK),
        .rstN     (rstN),
        .subIn    (subLink.consumer),
        .outReady (outReady),
        .outValid (outValid),
        .outWord  (outWord)
    );

endmodule

// ==== logic/aesSboxTable.svh ====
// forward AES S-box, row major, index is the input byte
localparam aesByte_t sboxTable [sboxDepth] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
};

// ==== logic/byteSubstitute.sv ====
`timescale 1ns/1ns

module byteSubstitute (
    input  logic                    CLK,
    input  logic                    rstN,
    input  logic                    inValid,
    input  aesRoundPkg::laneBytes_t stateIn,
    input  aesRoundPkg::aesWord_t   keyIn,
    input  aesRoundPkg::aesWord_t   plainIn,
    input  aesRoundPkg::roundOp_t   opIn,
    output logic                    inReady,
    subRoundIf.producer             subOut
);
    import aesRoundPkg::*;

    `include "aesSboxTable.svh"

    logic       fullQ;       // stage register holds an item
    logic       accept;
    laneBytes_t subD;
    laneBytes_t subQ;
    aesWord_t   keyQ;
    aesWord_t   plainQ;
    roundOp_t   opQ;

    // four independent lookups, one per lane
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            subD[i] = sboxTable[stateIn[i]];
        end
    end

    // free slot, or the item leaves toward stage 2 on this same edge
    assign inReady = !fullQ || subOut.ready;
    assign accept  = inValid && inReady;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            fullQ <= 1'b0;
        end else if (inReady) begin
            fullQ <= inValid;    // refill or drain
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            subQ   <= subD;
            keyQ   <= keyIn;
            plainQ <= plainIn;
            opQ    <= opIn;
        end
    end

    assign subOut.valid    = fullQ;
    assign subOut.subBytes = subQ;
    assign subOut.key      = keyQ;
    assign subOut.plain    = plainQ;
    assign subOut.op       = opQ;

endmodule

// ==== logic/roundCombine.sv ====
`timescale 1ns/1ns

module roundCombine (
    input  logic                  CLK,
    input  logic                  rstN,
    subRoundIf.consumer           subIn,
    input  logic                  outReady,
    output logic                  outValid,
    output aesRoundPkg::aesWord_t outWord
);
    import aesRoundPkg::*;

    logic     validQ;          // output register holds a word
    logic     take;
    aesWord_t rotCol [lanes];  // per-lane T-table equivalent
    aesWord_t mixed;
    aesWord_t resultD;
    aesWord_t wordQ;

    // xtime, multiply by x in GF(2^8)
    function automatic aesByte_t gfDouble(input aesByte_t b);
        aesByte_t shifted;
        shifted = {b[byteBits-2:0], 1'b0};
        return b[byteBits-1] ? (shifted ^ gfPoly) : shifted;
    endfunction

    // column word {2s, s, s, 3s} rotated right one byte per lane index,
    // which reproduces the four T-tables without storing them
    for (genvar i = 0; i < lanes; i++) begin : gLane
        aesByte_t sub;
        aesByte_t dbl;
        aesWord_t col;

        assign sub = subIn.subBytes[i];
        assign dbl = gfDouble(sub);
        assign col = {dbl, sub, sub, dbl ^ sub};    // dbl ^ sub is 3s

        // lane 0 passes unrotated, the left shift by a full word is zero
        assign rotCol[i] = (col >> (byteBits * i)) | (col << (wordBits - byteBits * i));
    end

    always_comb begin
        mixed = subIn.key;
        for (int i = 0; i < lanes; i++) begin
            mixed = mixed ^ rotCol[i];
        end
    end

    always_comb begin
        case (subIn.op)
            opInitial: resultD = subIn.plain ^ subIn.key;
            opMiddle:  resultD = mixed;
            opFinal:   resultD = subIn.subBytes ^ subIn.key;   // bytes stay in their lanes
            default:   resultD = subIn.plain ^ subIn.key;
        endcase
    end

    // take a new item when the output slot is free or being drained
    assign subIn.ready = !validQ || outReady;
    assign take        = subIn.valid && subIn.ready;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (subIn.ready) begin
            validQ <= subIn.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            wordQ <= resultD;
        end
    end

    assign outValid = validQ;
    assign outWord  = wordQ;

endmodule

// ==== logic/subRoundIf.sv ====
`timescale 1ns/1ns

interface subRoundIf;
    import aesRoundPkg::*;

    logic       valid;      // stage 1 holds an item
    roundOp_t   op;
    laneBytes_t subBytes;   // s-box outputs, lane 0 in the top byte
    aesWord_t   key;
    aesWord_t   plain;
    logic       ready;      // stage 2 can take the item this cycle

    modport producer (
        output valid,
        output op,
        output subBytes,
        output key,
        output plain,
        input  ready
    );

    modport consumer (
        input  valid,
        input  op,
        input  subBytes,
        input  key,
        input  plain,
        output ready
    );

endinterface

// ==== run.sh ====
#!/bin/sh
# compiles the testbench with Verilator and runs it, from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

if ! verilator --binary --timing --assert \
        -f filelist.f \
        --top-module aesRoundWordTb \
        -Mdir obj_dir \
        -o aesRoundWordSim; then
    echo "verilator build failed"
    exit 1
fi

if [ ! -x obj_dir/aesRoundWordSim ]; then
    echo "simulation binary missing"
    exit 1
fi

output=$(./obj_dir/aesRoundWordSim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict comes from the testbench text, not the exit code alone
if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

// ==== verification/aesRoundWordTb.sv ====
`timescale 1ns/1ns

module aesRoundWordTb;
    import aesRoundPkg::*;

    `include "aesSboxTable.svh"

    localparam int totalWords  = 400;
    localparam int burstWords  = 40;                  // back-to-back words at full rate
    localparam int clkPeriodNs = 100;
    localparam int resetCycles = 5;
    localparam int watchdogNs  = totalWords * 10 * clkPeriodNs;

    logic       CLK;
    logic       rstN;
    logic       inValid;
    logic       inReady;
    laneBytes_t stateIn;
    aesWord_t   keyIn;
    aesWord_t   plainIn;
    roundOp_t   opIn;
    logic       outValid;
    logic       outReady;
    aesWord_t   outWord;

    aesWord_t   expectQ [$];     // model results in acceptance order
    int         issuedCount;
    int         checkedCount;
    logic       heldValid;       // output was stalled at the last sample
    aesWord_t   heldWord;
    logic       inputWaiting;    // offered but not yet taken

    aesRoundWord dut_i (
        .CLK      (CLK),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .stateIn  (stateIn),
        .keyIn    (keyIn),
        .plainIn  (plainIn),
        .opIn     (opIn),
        .outValid (outValid),
        .outReady (outReady),
        .outWord  (outWord)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriodNs / 2) CLK = ~CLK;
    end

    initial begin
        #(watchdogNs);
        $display("timeout after %0d ns, %0d of %0d words checked",
                 watchdogNs, checkedCount, totalWords);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // multiply by x in GF(2^8)
    function automatic aesByte_t mulTwo(input aesByte_t b);
        return (b << 1) ^ (b[7] ? 8'h1B : 8'h00);
    endfunction

    function automatic aesByte_t mulThree(input aesByte_t b);
        return mulTwo(b) ^ b;
    endfunction

    // textbook round step on one gathered column
    function automatic aesWord_t modelWord(input roundOp_t op, input laneBytes_t st,
                                           input aesWord_t key, input aesWord_t plain);
        aesByte_t s [4];
        aesByte_t m [4];
        aesWord_t result;
        for (int i = 0; i < 4; i++) begin
            s[i] = sboxTable[st[i]];
        end
        m[0] = mulTwo(s[0]) ^ mulThree(s[1]) ^ s[2] ^ s[3];
        m[1] = s[0] ^ mulTwo(s[1]) ^ mulThree(s[2]) ^ s[3];
        m[2] = s[0] ^ s[1] ^ mulTwo(s[2]) ^ mulThree(s[3]);
        m[3] = mulThree(s[0]) ^ s[1] ^ s[2] ^ mulTwo(s[3]);
        case (op)
            opMiddle: result = {m[0], m[1], m[2], m[3]} ^ key;
            opFinal:  result = {s[0], s[1], s[2], s[3]} ^ key;
            default:  result = plain ^ key;
        endcase
        return result;
    endfunction

    function automatic roundOp_t pickOp();
        int pick;
        pick = $urandom % 3;
        if (pick == 0) begin
            return opInitial;
        end else if (pick == 1) begin
            return opMiddle;
        end else begin
            return opFinal;
        end
    endfunction

    task automatic stopRun();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input aesWord_t got, input aesWord_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic loadRandomWord();
        inValid = 1'b1;
        stateIn = $urandom();
        keyIn   = $urandom();
        plainIn = $urandom();
        opIn    = pickOp();
    endtask

    // runs mid cycle and sees what the next rising edge will transfer
    task automatic sampleCycle();
        aesWord_t expWord;
        if (heldValid) begin
            checkFlag(outValid, 1'b1, "outValid held under stall");
            checkWord(outWord, heldWord, "outWord held under stall");
        end
        if (outValid && outReady) begin
            if (expectQ.size() == 0) begin
                $display("output word %h at %0t ns with no accepted input left", outWord, $time);
                stopRun();
            end else begin
                expWord = expectQ.pop_front();
                checkWord(outWord, expWord, "outWord");
                checkedCount++;
            end
        end
        heldValid = outValid && !outReady;
        heldWord  = outWord;
        if (inValid && inReady) begin
            expectQ.push_back(modelWord(opIn, stateIn, keyIn, plainIn));
            issuedCount++;
        end
        inputWaiting = inValid && !inReady;
    endtask

    task automatic drainPipe();
        while (expectQ.size() != 0) begin
            @(negedge CLK);
            inValid  = 1'b0;
            outReady = 1'b1;
            #1;
            sampleCycle();
        end
    endtask

    initial begin
        laneBytes_t knownState;
        void'($urandom(32'h8929));
        rstN         = 1'b0;
        inValid      = 1'b0;
        stateIn      = '0;
        keyIn        = '0;
        plainIn      = '0;
        opIn         = opInitial;
        outReady     = 1'b0;
        issuedCount  = 0;
        checkedCount = 0;
        heldValid    = 1'b0;
        heldWord     = '0;
        inputWaiting = 1'b0;

        repeat (resetCycles) @(posedge CLK);
        @(negedge CLK);
        rstN     = 1'b1;
        outReady = 1'b1;
        #1;
        checkFlag(outValid, 1'b0, "outValid after reset");
        checkFlag(inReady, 1'b1, "inReady after reset");
        sampleCycle();

        // lane 0 gets 00 (s = 63) and the others get 52 with s-box value 00
        knownState = {8'h00, 8'h52, 8'h52, 8'h52};
        @(negedge CLK);
        inValid = 1'b1;
        stateIn = knownState;
        keyIn   = '0;
        plainIn = $urandom();
        opIn    = opMiddle;
        #1;
        checkFlag(inReady, 1'b1, "inReady for the known word");
        sampleCycle();
        @(negedge CLK);
        inValid = 1'b0;
        #1;
        sampleCycle();
        @(negedge CLK);
        #1;
        checkFlag(outValid, 1'b1, "outValid two edges after acceptance");
        checkWord(outWord, 32'hC66363A5, "known middle round word");
        sampleCycle();

        // at full rate the first word leaves two edges after its acceptance
        for (int k = 0; k < burstWords; k++) begin
            @(negedge CLK);
            loadRandomWord();
            outReady = 1'b1;
            #1;
            checkFlag(inReady, 1'b1, "inReady during burst");
            if (k >= 2) begin
                checkFlag(outValid, 1'b1, "outValid during burst");
            end
            sampleCycle();
        end
        drainPipe();

        while (checkedCount < totalWords) begin
            @(negedge CLK);
            if (!inputWaiting) begin
                if (issuedCount < totalWords && ($urandom % 100) < 70) begin
                    loadRandomWord();
                end else begin
                    inValid = 1'b0;
                end
            end
            outReady = ($urandom % 100) < 60;
            #1;
            sampleCycle();
        end

        @(negedge CLK);
        if (checkedCount == totalWords && issuedCount == totalWords && expectQ.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("run ended with %0d issued, %0d checked, %0d still queued",
                     issuedCount, checkedCount, expectQ.size());
            $display(">>> FAIL");
            $fatal(1, "word count wrong at end of run");
        end
    end

endmodule

// ==== verification/aesRoundWord_assert.sv ====
`timescale 1ns/1ns

module aesRoundWord_assert (
    input logic                  CLK,
    input logic                  rstN,
    input logic                  outValid,
    input logic                  outReady,
    input aesRoundPkg::aesWord_t outWord
);

    // nothing leaves the pipe while reset is applied or on the edge after it
    resetQuiet: assert property (@(posedge CLK) !rstN |=> !outValid)
        else $error("outValid high after a reset cycle");

    // a stalled word stays on the port until it is taken
    stallHold: assert property (@(posedge CLK) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outWord))
        else $error("output word changed or dropped while stalled");

    wordKnown: assert property (@(posedge CLK) disable iff (!rstN)
        outValid |-> !$isunknown(outWord))
        else $error("outWord has unknown bits while outValid is high");

endmodule

bind aesRoundWord aesRoundWord_assert handshakeChecks (
    .CLK      (CLK),
    .rstN     (rstN),
    .outValid (outValid),
    .outReady (outReady),
    .outWord  (outWord)
);
